// File: Makefile
# Verilator build and run for the CPS ROM download path

VERILATOR ?= verilator
TOP       ?= cps_rom_load_tb
FILELIST  ?= cps_rom_load.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation output holds the pass message
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: cps_dwnld_ctrl.sv
// #########################################################################
// ROM download sequencer
// Turns loader strobes into held SDRAM programming writes or into
// configuration and key capture pulses, depending on the byte's region
// #########################################################################

`timescale 1ns/100ps

module cps_dwnld_ctrl
    import cps_rom_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    downloading,
    input  logic    ioctl_wr,
    input  region_t region,
    input  logic    prog_rdy,
    output logic    load_prog,
    output logic    prog_we,
    output logic    cfg_we,
    output logic    kabuki_we,
    output logic    dwnld_busy
);

    localparam logic st_idle = 1'b0;
    localparam logic st_hold = 1'b1;

    logic state;
    logic byte_in;
    logic sdram_rgn;

    assign byte_in   = downloading & ioctl_wr;
    assign sdram_rgn = region inside {rgn_main, rgn_snd, rgn_pcm, rgn_gfx};

    // Packer samples the strobe cycle fields
    assign load_prog = byte_in & sdram_rgn & (state == st_idle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (load_prog) state <= st_hold;
                st_hold: if (prog_rdy) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // Capture pulses one cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_we    <= 1'b0;
            kabuki_we <= 1'b0;
        end else begin
            cfg_we    <= byte_in & (region == rgn_cfg);
            kabuki_we <= byte_in & (region == rgn_key);
        end
    end

    assign prog_we    = (state == st_hold);
    assign dwnld_busy = downloading | prog_we;

    // Loader waits for the SDRAM before the next byte
    a_no_wr_in_hold: assert property (
        @(posedge clk) disable iff (!rst_n) (state == st_hold) |-> !ioctl_wr
    ) else $error("cps_dwnld_ctrl: ioctl_wr while a write is pending");

    // Controller only answers a pending write
    a_rdy_in_hold: assert property (
        @(posedge clk) disable iff (!rst_n) prog_rdy |-> (state == st_hold)
    ) else $error("cps_dwnld_ctrl: prog_rdy with no write pending");

endmodule

// File: cps_key_regs.sv
// #########################################################################
// Configuration and Kabuki key capture
// Stores the board configuration bytes and the QSound decryption key
// found at the end of the ROM file. Flags a key that is not all zero
// #########################################################################

`timescale 1ns/100ps

module cps_key_regs
    import cps_rom_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cfg_we,
    input  logic                         kabuki_we,
    input  logic [$clog2(key_bytes)-1:0] key_index,
    input  logic [7:0]                   ioctl_data,
    output logic [cfg_bytes*8-1:0]       cfg_layout,
    output logic [key_bytes*8-1:0]       kabuki_key,
    output logic                         kabuki_en
);

    // Byte and index of the strobe cycle, used by the pulse one cycle later
    logic [7:0]                   data_q;
    logic [$clog2(key_bytes)-1:0] index_q;

    always_ff @(posedge clk) begin
        data_q  <= ioctl_data;
        index_q <= key_index;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_layout <= '0;
            kabuki_key <= '0;
            kabuki_en  <= 1'b0;
        end else begin
            if (cfg_we) begin
                cfg_layout[index_q[$clog2(cfg_bytes)-1:0]*8 +: 8] <= data_q;
            end
            if (kabuki_we) begin
                kabuki_key[index_q*8 +: 8] <= data_q;
                // Games without encryption ship an all zero key
                if (data_q != 8'd0) begin
                    kabuki_en <= 1'b1;
                end
            end
        end
    end

    // Regions are exclusive in the sequencer
    a_one_capture: assert property (
        @(posedge clk) disable iff (!rst_n) !(cfg_we && kabuki_we)
    ) else $error("cps_key_regs: cfg_we and kabuki_we together");

endmodule

// File: cps_prog_packer.sv
// #########################################################################
// SDRAM programming word packer
// Registers address, duplicated data byte, lane mask and bank of one
// download byte, held steady while the write waits for the controller
// #########################################################################

`timescale 1ns/100ps

module cps_prog_packer
    import cps_sdram_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_prog,
    input  logic [prog_addr_w-1:0] word_offset,
    input  logic                   byte_odd,
    input  bank_t                  bank,
    input  logic [7:0]             ioctl_data,
    output logic [prog_addr_w-1:0] prog_addr,
    output logic [15:0]            prog_data,
    output logic [1:0]             prog_mask,
    output bank_t                  prog_ba
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_addr <= '0;
            prog_data <= '0;
            // Nothing written until the first byte
            prog_mask <= 2'b11;
            prog_ba   <= bank_ram;
        end else if (load_prog) begin
            prog_addr <= word_offset;
            // Same byte on both lanes, mask picks the one written
            prog_data <= {ioctl_data, ioctl_data};
            // Even bytes land in the upper lane
            prog_mask <= byte_odd ? mask_lane_lo : mask_lane_hi;
            prog_ba   <= bank;
        end
    end

endmodule

// File: cps_rom_load.f
cps_sdram_pkg.sv
cps_rom_pkg.sv
cps_rom_region.sv
cps_prog_packer.sv
cps_key_regs.sv
cps_dwnld_ctrl.sv
cps_rom_load.sv
cps_rom_load_tb.sv

// File: cps_rom_load.sv
// #########################################################################
// CPS ROM download path
// Decodes the loader byte stream into SDRAM programming writes and
// captures the configuration and Kabuki key bytes
// #########################################################################

`timescale 1ns/100ps

module cps_rom_load
    import cps_rom_pkg::*, cps_sdram_pkg::*;
#(
    parameter logic [ioctl_addr_w-1:0] SND_START  = 25'h042_0000,
    parameter logic [ioctl_addr_w-1:0] PCM_START  = 25'h044_0000,
    parameter logic [ioctl_addr_w-1:0] GFX_START  = 25'h084_0000,
    parameter logic [ioctl_addr_w-1:0] CFG_START  = 25'h104_0000,
    parameter logic [ioctl_addr_w-1:0] KEY_START  = 25'h104_0004,
    parameter logic [ioctl_addr_w-1:0] ROM_END    = 25'h104_000C,
    parameter logic [prog_addr_w-1:0]  PCM_OFFSET = 22'h01_0000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    downloading,
    output logic                    dwnld_busy,
    // Loader byte stream
    input  logic [ioctl_addr_w-1:0] ioctl_addr,
    input  logic [7:0]              ioctl_data,
    input  logic                    ioctl_wr,
    // SDRAM programming
    output logic [prog_addr_w-1:0]  prog_addr,
    output logic [15:0]             prog_data,
    output logic [1:0]              prog_mask,
    output bank_t                   prog_ba,
    output logic                    prog_we,
    input  logic                    prog_rdy,
    // Board configuration and QSound key
    output logic                    cfg_we,
    output logic                    kabuki_we,
    output logic [cfg_bytes*8-1:0]  cfg_layout,
    output logic [key_bytes*8-1:0]  kabuki_key,
    output logic                    kabuki_en
);

    region_t                      region;
    bank_t                        bank;
    logic [prog_addr_w-1:0]       word_offset;
    logic                         byte_odd;
    logic [$clog2(key_bytes)-1:0] key_index;
    logic                         load_prog;

    cps_rom_region #(
        .SND_START  ( SND_START  ),
        .PCM_START  ( PCM_START  ),
        .GFX_START  ( GFX_START  ),
        .CFG_START  ( CFG_START  ),
        .KEY_START  ( KEY_START  ),
        .ROM_END    ( ROM_END    ),
        .PCM_OFFSET ( PCM_OFFSET )
    ) u_region (
        .ioctl_addr  ( ioctl_addr  ),
        .region      ( region      ),
        .bank        ( bank        ),
        .word_offset ( word_offset ),
        .byte_odd    ( byte_odd    ),
        .key_index   ( key_index   )
    );

    cps_dwnld_ctrl u_ctrl (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .region      ( region      ),
        .prog_rdy    ( prog_rdy    ),
        .load_prog   ( load_prog   ),
        .prog_we     ( prog_we     ),
        .cfg_we      ( cfg_we      ),
        .kabuki_we   ( kabuki_we   ),
        .dwnld_busy  ( dwnld_busy  )
    );

    cps_prog_packer u_packer (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .load_prog   ( load_prog   ),
        .word_offset ( word_offset ),
        .byte_odd    ( byte_odd    ),
        .bank        ( bank        ),
        .ioctl_data  ( ioctl_data  ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_ba     ( prog_ba     )
    );

    cps_key_regs u_keys (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .cfg_we      ( cfg_we      ),
        .kabuki_we   ( kabuki_we   ),
        .key_index   ( key_index   ),
        .ioctl_data  ( ioctl_data  ),
        .cfg_layout  ( cfg_layout  ),
        .kabuki_key  ( kabuki_key  ),
        .kabuki_en   ( kabuki_en   )
    );

endmodule

// File: cps_rom_load_tb.sv
// ###########################################################################
// Testbench for the CPS ROM download path
// Sends loader bytes into every file region, answers the SDRAM writes
// after a random delay and checks the write fields and captured key bytes
// ###########################################################################

`timescale 1ns/100ps

module cps_rom_load_tb
    import cps_rom_pkg::*, cps_sdram_pkg::*;
();

    localparam logic [ioctl_addr_w-1:0] snd_start  = 25'h100;
    localparam logic [ioctl_addr_w-1:0] pcm_start  = 25'h200;
    localparam logic [ioctl_addr_w-1:0] gfx_start  = 25'h300;
    localparam logic [ioctl_addr_w-1:0] cfg_start  = 25'h400;
    localparam logic [ioctl_addr_w-1:0] key_start  = 25'h404;
    localparam logic [ioctl_addr_w-1:0] rom_end    = 25'h40C;
    localparam logic [prog_addr_w-1:0]  pcm_offset = 22'h1000;

    localparam int clk_period     = 4;
    // Bytes sent over all tests with 20 cycles allowed for each
    localparam int n_bytes        = 49;
    localparam int timeout_cycles = n_bytes * 20 + 50;

    logic                    clk;
    logic                    rst_n;
    logic                    downloading;
    logic [ioctl_addr_w-1:0] ioctl_addr;
    logic [7:0]              ioctl_data;
    logic                    ioctl_wr;
    logic                    prog_rdy;
    logic                    dwnld_busy;
    logic [prog_addr_w-1:0]  prog_addr;
    logic [15:0]             prog_data;
    logic [1:0]              prog_mask;
    bank_t                   prog_ba;
    logic                    prog_we;
    logic                    cfg_we;
    logic                    kabuki_we;
    logic [cfg_bytes*8-1:0]  cfg_layout;
    logic [key_bytes*8-1:0]  kabuki_key;
    logic                    kabuki_en;

    // Expected contents of the capture registers
    logic [cfg_bytes*8-1:0]  exp_cfg;
    logic [key_bytes*8-1:0]  exp_key;
    logic                    exp_en;
    int                      errors;
    int                      checks;
    int unsigned             seed_init;

    cps_rom_load #(
        .SND_START  ( snd_start  ),
        .PCM_START  ( pcm_start  ),
        .GFX_START  ( gfx_start  ),
        .CFG_START  ( cfg_start  ),
        .KEY_START  ( key_start  ),
        .ROM_END    ( rom_end    ),
        .PCM_OFFSET ( pcm_offset )
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic region_t region_of(input logic [ioctl_addr_w-1:0] addr);
        if (addr < snd_start) return rgn_main;
        if (addr < pcm_start) return rgn_snd;
        if (addr < gfx_start) return rgn_pcm;
        if (addr < cfg_start) return rgn_gfx;
        if (addr < key_start) return rgn_cfg;
        if (addr < rom_end) return rgn_key;
        return rgn_none;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR [%0t] %s: got %0h, expected %0h", $time, msg, actual, expected);
        end
    endtask

    task automatic compare_capture_regs(input string msg);
        check_value(cfg_layout, exp_cfg, {msg, ", cfg_layout"});
        check_value(kabuki_key, exp_key, {msg, ", kabuki_key"});
        check_value(kabuki_en, exp_en, {msg, ", kabuki_en"});
    endtask

    // One loader strobe that returns in the middle of cycle n+1
    task automatic strobe_byte(input logic [ioctl_addr_w-1:0] addr, input logic [7:0] data,
                               input logic dl_after);
        @(posedge clk);
        ioctl_addr <= addr;
        ioctl_data <= data;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr    <= 1'b0;
        downloading <= dl_after;
        // Loader lines move on once the strobe is over
        ioctl_addr  <= ~addr;
        ioctl_data  <= ~data;
        @(negedge clk);
    endtask

    // SDRAM write answered with prog_rdy after delay cycles
    task automatic hold_write(input logic [ioctl_addr_w-1:0] addr, input logic [7:0] data,
                              input int delay, input logic dl_after);
        region_t                 rgn;
        logic [ioctl_addr_w-1:0] off;
        logic [prog_addr_w-1:0]  exp_addr;
        bank_t                   exp_ba;
        rgn      = region_of(addr);
        off      = addr - (rgn == rgn_snd ? snd_start : rgn == rgn_pcm ? pcm_start :
                           rgn == rgn_gfx ? gfx_start : 25'h0);
        exp_addr = off[prog_addr_w:1] + (rgn == rgn_pcm ? pcm_offset : 22'h0);
        exp_ba   = rgn == rgn_main ? bank_main : rgn == rgn_gfx ? bank_gfx : bank_snd;
        strobe_byte(addr, data, dl_after);
        for (int i = 0; i <= delay + 1; i++) begin
            check_value(prog_we, 1'b1, "prog_we held");
            check_value(prog_addr, exp_addr, "prog_addr");
            check_value(prog_data, {data, data}, "prog_data");
            check_value(prog_mask, addr[0] ? mask_lane_lo : mask_lane_hi, "prog_mask");
            check_value(prog_ba, exp_ba, "prog_ba");
            check_value(dwnld_busy, 1'b1, "dwnld_busy during write");
            check_value(cfg_we | kabuki_we, 1'b0, "capture pulse during write");
            @(posedge clk);
            prog_rdy <= (i == delay);
            @(negedge clk);
        end
        check_value(prog_we, 1'b0, "prog_we after prog_rdy");
        check_value(dwnld_busy, downloading, "dwnld_busy after write");
    endtask

    task automatic capture_byte(input logic [ioctl_addr_w-1:0] addr, input logic [7:0] data);
        logic is_cfg;
        int   idx;
        is_cfg = (region_of(addr) == rgn_cfg);
        idx    = is_cfg ? int'(addr - cfg_start) : int'(addr - key_start);
        strobe_byte(addr, data, 1'b1);
        check_value(cfg_we, is_cfg, "cfg_we pulse");
        check_value(kabuki_we, !is_cfg, "kabuki_we pulse");
        check_value(prog_we, 1'b0, "prog_we on capture byte");
        if (is_cfg) begin
            exp_cfg[idx*8 +: 8] = data;
        end else begin
            exp_key[idx*8 +: 8] = data;
            exp_en = exp_en | (data != 8'd0);
        end
        @(negedge clk);
        check_value(cfg_we | kabuki_we, 1'b0, "second capture pulse");
        compare_capture_regs("after capture");
    endtask

    task automatic ignore_byte(input logic [ioctl_addr_w-1:0] addr, input logic [7:0] data);
        strobe_byte(addr, data, 1'b1);
        repeat (2) begin
            check_value({prog_we, cfg_we, kabuki_we}, 3'b000, "pulse on ignored byte");
            @(negedge clk);
        end
        compare_capture_regs("after ignored byte");
    endtask

    task automatic send_byte(input logic [ioctl_addr_w-1:0] addr, input logic [7:0] data);
        case (region_of(addr))
            rgn_cfg, rgn_key: capture_byte(addr, data);
            rgn_none:         ignore_byte(addr, data);
            default:          hold_write(addr, data, $urandom_range(0, 5), 1'b1);
        endcase
    endtask

    task automatic expect_reset_state();
        @(negedge clk);
        check_value({prog_we, cfg_we, kabuki_we, dwnld_busy}, 4'b0, "outputs after reset");
        compare_capture_regs("after reset");
    endtask

    task automatic sweep_regions();
        logic [ioctl_addr_w-1:0] starts [4];
        starts = '{25'h0, snd_start, pcm_start, gfx_start};
        @(posedge clk);
        downloading <= 1'b1;
        foreach (starts[r]) begin
            repeat (8) begin
                send_byte(starts[r] + 25'($urandom_range(0, 255)), 8'($urandom));
            end
        end
    endtask

    task automatic stall_writes();
        // Loader done while the write is still pending
        hold_write(gfx_start + 25'h2b, 8'h5a, 5, 1'b0);
        @(posedge clk);
        downloading <= 1'b1;
        @(negedge clk);
        check_value(dwnld_busy, 1'b1, "dwnld_busy with downloading");
        hold_write(25'h0c4, 8'hc3, 5, 1'b1);
    endtask

    task automatic load_cfg_and_key();
        for (int i = 0; i < cfg_bytes; i++) begin
            send_byte(cfg_start + 25'(i), 8'($urandom));
        end
        // Zero key bytes keep decryption off
        for (int i = 0; i < 3; i++) begin
            send_byte(key_start + 25'(i), 8'h00);
        end
        check_value(kabuki_en, 1'b0, "kabuki_en after zero key bytes");
        for (int i = 3; i < key_bytes; i++) begin
            send_byte(key_start + 25'(i), 8'($urandom) | 8'h01);
        end
        check_value(kabuki_en, 1'b1, "kabuki_en after nonzero key byte");
    endtask

    task automatic drop_out_of_range();
        send_byte(rom_end, 8'hff);
        send_byte(rom_end + 25'h7, 8'h3c);
        send_byte(25'h1ff_ffff, 8'h81);
    endtask

    initial begin
        seed_init   = $urandom(32'h74c6a601);
        errors      = 0;
        checks      = 0;
        exp_cfg     = '0;
        exp_key     = '0;
        exp_en      = 1'b0;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        prog_rdy    = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        expect_reset_state();
        sweep_regions();
        stall_writes();
        load_cfg_and_key();
        drop_out_of_range();
        @(posedge clk);
        downloading <= 1'b0;
        @(negedge clk);
        check_value(dwnld_busy, 1'b0, "dwnld_busy after download");
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Watchdog timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: cps_rom_pkg.sv
// #########################################################################
// CPS ROM file layout definitions
// Loader address width, region codes and the sizes of the board
// configuration and Kabuki key areas at the end of the file
// #########################################################################

package cps_rom_pkg;

    // Byte address width of the loader
    localparam int ioctl_addr_w = 25;

    // Regions of the downloaded file, in file order
    typedef enum logic [2:0] {
        rgn_main = 3'd0,
        rgn_snd  = 3'd1,
        rgn_pcm  = 3'd2,
        rgn_gfx  = 3'd3,
        rgn_cfg  = 3'd4,
        rgn_key  = 3'd5,
        rgn_none = 3'd7
    } region_t;

    // Board configuration bytes, CPS-B layout
    localparam int cfg_bytes = 4;

    // QSound Kabuki decryption key bytes
    localparam int key_bytes = 8;

endpackage

// File: cps_rom_region.sv
// #########################################################################
// ROM region decoder
// Maps a loader byte address to its region, SDRAM bank and word offset.
// Also gives the byte index inside the configuration and key areas
// #########################################################################

`timescale 1ns/100ps

module cps_rom_region
    import cps_rom_pkg::*, cps_sdram_pkg::*;
#(
    parameter logic [ioctl_addr_w-1:0] SND_START  = 25'h042_0000,
    parameter logic [ioctl_addr_w-1:0] PCM_START  = 25'h044_0000,
    parameter logic [ioctl_addr_w-1:0] GFX_START  = 25'h084_0000,
    parameter logic [ioctl_addr_w-1:0] CFG_START  = 25'h104_0000,
    parameter logic [ioctl_addr_w-1:0] KEY_START  = 25'h104_0004,
    parameter logic [ioctl_addr_w-1:0] ROM_END    = 25'h104_000C,
    parameter logic [prog_addr_w-1:0]  PCM_OFFSET = 22'h01_0000
) (
    input  logic [ioctl_addr_w-1:0]      ioctl_addr,
    output region_t                      region,
    output bank_t                        bank,
    output logic [prog_addr_w-1:0]       word_offset,
    output logic                         byte_odd,
    output logic [$clog2(key_bytes)-1:0] key_index
);

    logic [ioctl_addr_w-1:0] rgn_base;
    logic [ioctl_addr_w-1:0] offset;
    logic [prog_addr_w-1:0]  pcm_add;

    // Main code starts at byte 0
    always_comb begin
        region   = rgn_none;
        rgn_base = '0;
        if (ioctl_addr < SND_START) begin
            region = rgn_main;
        end else if (ioctl_addr < PCM_START) begin
            region   = rgn_snd;
            rgn_base = SND_START;
        end else if (ioctl_addr < GFX_START) begin
            region   = rgn_pcm;
            rgn_base = PCM_START;
        end else if (ioctl_addr < CFG_START) begin
            region   = rgn_gfx;
            rgn_base = GFX_START;
        end else if (ioctl_addr < KEY_START) begin
            region   = rgn_cfg;
            rgn_base = CFG_START;
        end else if (ioctl_addr < ROM_END) begin
            region   = rgn_key;
            rgn_base = KEY_START;
        end
    end

    assign offset = ioctl_addr - rgn_base;

    always_comb begin
        case (region)
            rgn_main:         bank = bank_main;
            rgn_snd, rgn_pcm: bank = bank_snd;
            rgn_gfx:          bank = bank_gfx;
            default:          bank = bank_ram;
        endcase
    end

    // PCM samples follow the sound code inside bank 1
    assign pcm_add     = (region == rgn_pcm) ? PCM_OFFSET : '0;
    assign word_offset = offset[prog_addr_w:1] + pcm_add;
    assign byte_odd    = ioctl_addr[0];

    assign key_index = (region == rgn_cfg || region == rgn_key) ?
                       offset[$clog2(key_bytes)-1:0] : '0;

    // Layout sanity, checked once at start of simulation
    initial begin
        assert (SND_START < PCM_START && PCM_START < GFX_START &&
                GFX_START < CFG_START && CFG_START < KEY_START &&
                KEY_START < ROM_END)
            else $error("cps_rom_region: region starts not ascending");
        assert (KEY_START - CFG_START == cfg_bytes && ROM_END - KEY_START == key_bytes)
            else $error("cps_rom_region: cfg or key area size mismatch");
    end

endmodule

// File: cps_sdram_pkg.sv
// #########################################################################
// CPS SDRAM programming definitions
// Word address width, bank codes and byte lane write masks seen by the
// SDRAM controller while the ROM file is being loaded
// #########################################################################

package cps_sdram_pkg;

    // 4M x 16 words per bank
    localparam int prog_addr_w = 22;

    // Bank assignment of the ROM contents
    typedef enum logic [1:0] {
        bank_ram  = 2'd0,
        bank_snd  = 2'd1,
        bank_gfx  = 2'd2,
        bank_main = 2'd3
    } bank_t;

    // A set mask bit leaves that lane untouched
    localparam logic [1:0] mask_lane_hi = 2'b01;
    localparam logic [1:0] mask_lane_lo = 2'b10;

endpackage
